//--- logic/control_cfg.svh
`ifndef CONTROL_CFG_SVH
`define CONTROL_CFG_SVH

// Instruction fields
`define OPCODE_W    6
`define FUNCT_W     6

`define OP_RTYPE    6'h00
`define OP_ADDI     6'h08

// R-format funct codes
`define FN_ADD      6'h20
`define FN_SUB      6'h22
`define FN_AND      6'h24
`define FN_SLL      6'h00
`define FN_SRL      6'h02
`define FN_SRA      6'h03
`define FN_SLLV     6'h04
`define FN_SRAV     6'h07
`define FN_SLT      6'h2A
`define FN_BREAK    6'h0D

// Control word field widths
`define REGDST_W    2
`define ALUSRCA_W   2
`define SHAMTSEL_W  2
`define ALUSRCB_W   3
`define ALUOP_W     3
`define MEMTOREG_W  3
`define SHIFTOP_W   3

`endif

//--- logic/controlPkg.sv
package controlPkg;

    // Sequencer states, common steps first
    typedef enum logic [5:0] {
        Fetch,
        PcWait,
        IrLoad,
        Decode,
        DecodeWait,
        AluAdd,
        AluSub,
        AluAnd,
        AluEnd,
        ShiftLoadShamt,
        ShiftLoadRt,
        ShiftSll,
        ShiftSrl,
        ShiftSra,
        ShiftSllv,
        ShiftSrav,
        ShiftWait,
        ShiftEnd,
        Slt,
        Break,
        Addi,
        ImmEnd,
        Delay
    } ctrlState;

    // Decoded instruction classes
    typedef enum logic [3:0] {
        KAdd,
        KSub,
        KAnd,
        KSll,
        KSrl,
        KSra,
        KSllv,
        KSrav,
        KSlt,
        KBreak,
        KAddi,
        KUnknown
    } instrKind;

endpackage

//--- logic/ctrlBus.sv
`timescale 1ns/1ps
`include "control_cfg.svh"

interface ctrlBus;

    // Write enables and pulses
    logic                     pcWrite;
    logic                     irWrite;
    logic                     regWrite;
    logic                     aWrite;
    logic                     bWrite;
    logic                     aluOutWrite;
    logic                     shiftSrc;

    // Mux selects and operation codes
    logic [`REGDST_W-1:0]     regDst;
    logic [`ALUSRCA_W-1:0]    aluSrcA;
    logic [`SHAMTSEL_W-1:0]   shamtSel;
    logic [`ALUSRCB_W-1:0]    aluSrcB;
    logic [`ALUOP_W-1:0]      aluOp;
    logic [`MEMTOREG_W-1:0]   memToReg;
    logic [`SHIFTOP_W-1:0]    shiftOp;

    modport encoder (
        output pcWrite, irWrite, regWrite, aWrite, bWrite, aluOutWrite, shiftSrc,
        output regDst, aluSrcA, shamtSel, aluSrcB, aluOp, memToReg, shiftOp
    );

    modport top (
        input pcWrite, irWrite, regWrite, aWrite, bWrite, aluOutWrite, shiftSrc,
        input regDst, aluSrcA, shamtSel, aluSrcB, aluOp, memToReg, shiftOp
    );

endinterface

//--- logic/instrDecoder.sv
`timescale 1ns/1ps
`include "control_cfg.svh"

module instrDecoder (
    input  logic [`OPCODE_W-1:0]  opcode,
    input  logic [`FUNCT_W-1:0]   funct,
    output controlPkg::instrKind  kind
);

    always_comb begin
        kind = controlPkg::KUnknown;
        case (opcode)
            `OP_RTYPE: begin
                // R-format is told apart by funct alone
                case (funct)
                    `FN_ADD:   kind = controlPkg::KAdd;
                    `FN_SUB:   kind = controlPkg::KSub;
                    `FN_AND:   kind = controlPkg::KAnd;
                    `FN_SLL:   kind = controlPkg::KSll;
                    `FN_SRL:   kind = controlPkg::KSrl;
                    `FN_SRA:   kind = controlPkg::KSra;
                    `FN_SLLV:  kind = controlPkg::KSllv;
                    `FN_SRAV:  kind = controlPkg::KSrav;
                    `FN_SLT:   kind = controlPkg::KSlt;
                    `FN_BREAK: kind = controlPkg::KBreak;
                    default:   kind = controlPkg::KUnknown;
                endcase
            end
            `OP_ADDI: begin
                kind = controlPkg::KAddi;
            end
            default: begin
                kind = controlPkg::KUnknown;
            end
        endcase
    end

endmodule

//--- logic/controlSequencer.sv
`timescale 1ns/1ps
`include "control_cfg.svh"

module controlSequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  controlPkg::instrKind  kind,
    output controlPkg::ctrlState  state
);

    controlPkg::ctrlState  nextState;
    controlPkg::instrKind  kindHeld;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= controlPkg::Fetch;
            kindHeld <= controlPkg::KUnknown;
        end else begin
            state <= nextState;
            // Opcode and funct are only valid through DecodeWait
            if (state == controlPkg::DecodeWait) begin
                kindHeld <= kind;
            end
        end
    end

    always_comb begin
        nextState = controlPkg::Fetch;
        case (state)
            controlPkg::Fetch:      nextState = controlPkg::PcWait;
            controlPkg::PcWait:     nextState = controlPkg::IrLoad;
            controlPkg::IrLoad:     nextState = controlPkg::Decode;
            controlPkg::Decode:     nextState = controlPkg::DecodeWait;
            controlPkg::DecodeWait: begin
                case (kind)
                    controlPkg::KAdd:   nextState = controlPkg::AluAdd;
                    controlPkg::KSub:   nextState = controlPkg::AluSub;
                    controlPkg::KAnd:   nextState = controlPkg::AluAnd;
                    controlPkg::KSll,
                    controlPkg::KSrl,
                    controlPkg::KSra:   nextState = controlPkg::ShiftLoadShamt;
                    controlPkg::KSllv,
                    controlPkg::KSrav:  nextState = controlPkg::ShiftLoadRt;
                    controlPkg::KSlt:   nextState = controlPkg::Slt;
                    controlPkg::KBreak: nextState = controlPkg::Break;
                    controlPkg::KAddi:  nextState = controlPkg::Addi;
                    // Unrecognized encodings skip straight to the delay step
                    default:            nextState = controlPkg::Delay;
                endcase
            end
            controlPkg::AluAdd,
            controlPkg::AluSub,
            controlPkg::AluAnd:     nextState = controlPkg::AluEnd;
            controlPkg::ShiftLoadShamt: begin
                case (kindHeld)
                    controlPkg::KSrl: nextState = controlPkg::ShiftSrl;
                    controlPkg::KSra: nextState = controlPkg::ShiftSra;
                    default:          nextState = controlPkg::ShiftSll;
                endcase
            end
            controlPkg::ShiftLoadRt: begin
                if (kindHeld == controlPkg::KSrav) begin
                    nextState = controlPkg::ShiftSrav;
                end else begin
                    nextState = controlPkg::ShiftSllv;
                end
            end
            controlPkg::ShiftSll,
            controlPkg::ShiftSrl,
            controlPkg::ShiftSra,
            controlPkg::ShiftSllv,
            controlPkg::ShiftSrav:  nextState = controlPkg::ShiftWait;
            controlPkg::ShiftWait:  nextState = controlPkg::ShiftEnd;
            controlPkg::Addi:       nextState = controlPkg::ImmEnd;
            controlPkg::AluEnd,
            controlPkg::ShiftEnd,
            controlPkg::Slt,
            controlPkg::Break,
            controlPkg::ImmEnd:     nextState = controlPkg::Delay;
            controlPkg::Delay:      nextState = controlPkg::Fetch;
            default:                nextState = controlPkg::Fetch;
        endcase
    end

endmodule

//--- logic/controlEncoder.sv
`timescale 1ns/1ps
`include "control_cfg.svh"

module controlEncoder (
    input  logic                  clk,
    input  logic                  reset,
    input  controlPkg::ctrlState  state,
    ctrlBus.encoder               bus
);

    // Word of the state being left, so outputs trail the state by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            bus.pcWrite     <= 1'b0;
            bus.irWrite     <= 1'b0;
            bus.regWrite    <= 1'b0;
            bus.aWrite      <= 1'b0;
            bus.bWrite      <= 1'b0;
            bus.aluOutWrite <= 1'b0;
            bus.shiftSrc    <= 1'b0;
            bus.regDst      <= '0;
            bus.aluSrcA     <= '0;
            bus.shamtSel    <= '0;
            bus.aluSrcB     <= '0;
            bus.aluOp       <= '0;
            bus.memToReg    <= '0;
            bus.shiftOp     <= '0;
        end else begin
            // Everything idles unless the state below says otherwise
            bus.pcWrite     <= 1'b0;
            bus.irWrite     <= 1'b0;
            bus.regWrite    <= 1'b0;
            bus.aWrite      <= 1'b0;
            bus.bWrite      <= 1'b0;
            bus.aluOutWrite <= 1'b0;
            bus.shiftSrc    <= 1'b0;
            bus.regDst      <= '0;
            bus.aluSrcA     <= '0;
            bus.shamtSel    <= '0;
            bus.aluSrcB     <= '0;
            bus.aluOp       <= '0;
            bus.memToReg    <= '0;
            bus.shiftOp     <= '0;
            case (state)
                controlPkg::Fetch: begin
                    // PC + 4 on the ALU
                    bus.aluSrcB <= `ALUSRCB_W'(1);
                    bus.aluOp   <= `ALUOP_W'(1);
                end
                controlPkg::PcWait: begin
                    bus.pcWrite <= 1'b1;
                    bus.aluSrcB <= `ALUSRCB_W'(1);
                    bus.aluOp   <= `ALUOP_W'(1);
                end
                controlPkg::IrLoad: begin
                    bus.irWrite  <= 1'b1;
                    bus.aluSrcB  <= `ALUSRCB_W'(1);
                    bus.memToReg <= `MEMTOREG_W'(3);
                end
                controlPkg::Decode: begin
                    // Load A and B, branch target into ALUOut
                    bus.aWrite      <= 1'b1;
                    bus.bWrite      <= 1'b1;
                    bus.aluOutWrite <= 1'b1;
                    bus.aluSrcB     <= `ALUSRCB_W'(4);
                    bus.aluOp       <= `ALUOP_W'(1);
                    bus.memToReg    <= `MEMTOREG_W'(3);
                end
                controlPkg::DecodeWait: begin
                    bus.aluOp    <= `ALUOP_W'(1);
                    bus.memToReg <= `MEMTOREG_W'(3);
                end
                controlPkg::AluAdd,
                controlPkg::AluSub,
                controlPkg::AluAnd: begin
                    bus.aluOutWrite <= 1'b1;
                    bus.aluSrcA     <= `ALUSRCA_W'(1);
                    if (state == controlPkg::AluAdd) begin
                        bus.aluOp <= `ALUOP_W'(1);
                    end else if (state == controlPkg::AluSub) begin
                        bus.aluOp <= `ALUOP_W'(2);
                    end else begin
                        bus.aluOp <= `ALUOP_W'(3);
                    end
                end
                controlPkg::AluEnd: begin
                    bus.regWrite <= 1'b1;
                    bus.regDst   <= `REGDST_W'(3);
                end
                controlPkg::ShiftLoadShamt: begin
                    bus.shiftSrc <= 1'b1;
                    bus.shiftOp  <= `SHIFTOP_W'(1);
                end
                controlPkg::ShiftLoadRt: begin
                    // Shift amount comes from rt
                    bus.shamtSel <= `SHAMTSEL_W'(3);
                    bus.shiftOp  <= `SHIFTOP_W'(1);
                end
                controlPkg::ShiftSll: begin
                    bus.shiftSrc <= 1'b1;
                    bus.shiftOp  <= `SHIFTOP_W'(2);
                end
                controlPkg::ShiftSllv: begin
                    bus.shiftOp <= `SHIFTOP_W'(2);
                end
                controlPkg::ShiftSrl: begin
                    bus.shiftOp <= `SHIFTOP_W'(3);
                end
                controlPkg::ShiftSra,
                controlPkg::ShiftSrav: begin
                    bus.shiftOp <= `SHIFTOP_W'(4);
                end
                controlPkg::ShiftEnd: begin
                    bus.regWrite <= 1'b1;
                    bus.regDst   <= `REGDST_W'(3);
                    bus.memToReg <= `MEMTOREG_W'(2);
                end
                controlPkg::Slt: begin
                    bus.regWrite <= 1'b1;
                    bus.regDst   <= `REGDST_W'(3);
                    bus.aluSrcA  <= `ALUSRCA_W'(1);
                    bus.memToReg <= `MEMTOREG_W'(4);
                    bus.aluOp    <= `ALUOP_W'(7);
                end
                controlPkg::Break: begin
                    bus.pcWrite <= 1'b1;
                    bus.aluSrcB <= `ALUSRCB_W'(1);
                    bus.aluOp   <= `ALUOP_W'(2);
                end
                controlPkg::Addi: begin
                    // Sign-extended immediate on B
                    bus.aluOutWrite <= 1'b1;
                    bus.aluSrcA     <= `ALUSRCA_W'(1);
                    bus.aluSrcB     <= `ALUSRCB_W'(3);
                    bus.aluOp       <= `ALUOP_W'(1);
                end
                controlPkg::ImmEnd: begin
                    bus.regWrite <= 1'b1;
                end
                default: begin
                    // ShiftWait and Delay keep the idle word
                end
            endcase
        end
    end

endmodule

//--- logic/multicycleControl.sv
`timescale 1ns/1ps
`include "control_cfg.svh"

module multicycleControl (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`OPCODE_W-1:0]     opcode,
    input  logic [`FUNCT_W-1:0]      funct,

    output logic                     pcWrite,
    output logic                     irWrite,
    output logic                     regWrite,
    output logic                     aWrite,
    output logic                     bWrite,
    output logic                     aluOutWrite,
    output logic                     shiftSrc,
    output logic [`REGDST_W-1:0]     regDst,
    output logic [`ALUSRCA_W-1:0]    aluSrcA,
    output logic [`SHAMTSEL_W-1:0]   shamtSel,
    output logic [`ALUSRCB_W-1:0]    aluSrcB,
    output logic [`ALUOP_W-1:0]      aluOp,
    output logic [`MEMTOREG_W-1:0]   memToReg,
    output logic [`SHIFTOP_W-1:0]    shiftOp
);

    controlPkg::instrKind  kind;
    controlPkg::ctrlState  state;

    ctrlBus ctrlWord ();

    instrDecoder u_decoder (
        .opcode (opcode),
        .funct  (funct),
        .kind   (kind)
    );

    controlSequencer u_sequencer (
        .clk   (clk),
        .reset (reset),
        .kind  (kind),
        .state (state)
    );

    controlEncoder u_encoder (
        .clk   (clk),
        .reset (reset),
        .state (state),
        .bus   (ctrlWord.encoder)
    );

    assign pcWrite     = ctrlWord.pcWrite;
    assign irWrite     = ctrlWord.irWrite;
    assign regWrite    = ctrlWord.regWrite;
    assign aWrite      = ctrlWord.aWrite;
    assign bWrite      = ctrlWord.bWrite;
    assign aluOutWrite = ctrlWord.aluOutWrite;
    assign shiftSrc    = ctrlWord.shiftSrc;
    assign regDst      = ctrlWord.regDst;
    assign aluSrcA     = ctrlWord.aluSrcA;
    assign shamtSel    = ctrlWord.shamtSel;
    assign aluSrcB     = ctrlWord.aluSrcB;
    assign aluOp       = ctrlWord.aluOp;
    assign memToReg    = ctrlWord.memToReg;
    assign shiftOp     = ctrlWord.shiftOp;

endmodule

//--- tb/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Reset spans the first three rising edges
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- tb/multicycleControlTb.sv
`timescale 1ns/1ps
`include "control_cfg.svh"

module multicycleControlTb;

    localparam int NUM_INSTR  = 200;
    localparam int MAX_CYCLES = NUM_INSTR * 10 + 50;

    localparam logic [`FUNCT_W-1:0] FUNCTS [10] = '{`FN_ADD, `FN_SUB, `FN_AND, `FN_SLL,
        `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRAV, `FN_SLT, `FN_BREAK};
    localparam controlPkg::instrKind KINDS [10] = '{controlPkg::KAdd, controlPkg::KSub,
        controlPkg::KAnd, controlPkg::KSll, controlPkg::KSrl, controlPkg::KSra,
        controlPkg::KSllv, controlPkg::KSrav, controlPkg::KSlt, controlPkg::KBreak};

    logic                  clk;
    logic                  reset;
    logic [`OPCODE_W-1:0]  opcode;
    logic [`FUNCT_W-1:0]   funct;
    wire  [24:0]           dutWord;
    integer                seed;
    int                    cycleCount = 0;
    controlPkg::ctrlState  route[$];

    clockGen u_clock (
        .clk   (clk),
        .reset (reset)
    );

    multicycleControl i_dut (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .funct       (funct),
        .pcWrite     (dutWord[24]),
        .irWrite     (dutWord[23]),
        .regWrite    (dutWord[22]),
        .aWrite      (dutWord[21]),
        .bWrite      (dutWord[20]),
        .aluOutWrite (dutWord[19]),
        .shiftSrc    (dutWord[18]),
        .regDst      (dutWord[17:16]),
        .aluSrcA     (dutWord[15:14]),
        .shamtSel    (dutWord[13:12]),
        .aluSrcB     (dutWord[11:9]),
        .aluOp       (dutWord[8:6]),
        .memToReg    (dutWord[5:3]),
        .shiftOp     (dutWord[2:0])
    );

    // Columns: pc ir reg a b aluOut shiftSrc enables, regDst, aluSrcA, shamtSel,
    // aluSrcB, aluOp, memToReg, shiftOp
    function automatic logic [24:0] wordOf(input controlPkg::ctrlState s);
        logic [24:0] w;
        w = '0;
        case (s)
            controlPkg::Fetch:          w = {7'b0000000, 2'd0, 2'd0, 2'd0, 3'd1, 3'd1, 3'd0, 3'd0};
            controlPkg::PcWait:         w = {7'b1000000, 2'd0, 2'd0, 2'd0, 3'd1, 3'd1, 3'd0, 3'd0};
            controlPkg::IrLoad:         w = {7'b0100000, 2'd0, 2'd0, 2'd0, 3'd1, 3'd0, 3'd3, 3'd0};
            controlPkg::Decode:         w = {7'b0001110, 2'd0, 2'd0, 2'd0, 3'd4, 3'd1, 3'd3, 3'd0};
            controlPkg::DecodeWait:     w = {7'b0000000, 2'd0, 2'd0, 2'd0, 3'd0, 3'd1, 3'd3, 3'd0};
            controlPkg::AluAdd:         w = {7'b0000010, 2'd0, 2'd1, 2'd0, 3'd0, 3'd1, 3'd0, 3'd0};
            controlPkg::AluSub:         w = {7'b0000010, 2'd0, 2'd1, 2'd0, 3'd0, 3'd2, 3'd0, 3'd0};
            controlPkg::AluAnd:         w = {7'b0000010, 2'd0, 2'd1, 2'd0, 3'd0, 3'd3, 3'd0, 3'd0};
            controlPkg::AluEnd:         w = {7'b0010000, 2'd3, 2'd0, 2'd0, 3'd0, 3'd0, 3'd0, 3'd0};
            controlPkg::ShiftLoadShamt: w = {7'b0000001, 2'd0, 2'd0, 2'd0, 3'd0, 3'd0, 3'd0, 3'd1};
            controlPkg::ShiftLoadRt:    w = {7'b0000000, 2'd0, 2'd0, 2'd3, 3'd0, 3'd0, 3'd0, 3'd1};
            controlPkg::ShiftSll:       w = {7'b0000001, 2'd0, 2'd0, 2'd0, 3'd0, 3'd0, 3'd0, 3'd2};
            controlPkg::ShiftSllv:      w = {7'b0000000, 2'd0, 2'd0, 2'd0, 3'd0, 3'd0, 3'd0, 3'd2};
            controlPkg::ShiftSrl:       w = {7'b0000000, 2'd0, 2'd0, 2'd0, 3'd0, 3'd0, 3'd0, 3'd3};
            controlPkg::ShiftSra:       w = {7'b0000000, 2'd0, 2'd0, 2'd0, 3'd0, 3'd0, 3'd0, 3'd4};
            controlPkg::ShiftSrav:      w = {7'b0000000, 2'd0, 2'd0, 2'd0, 3'd0, 3'd0, 3'd0, 3'd4};
            controlPkg::ShiftEnd:       w = {7'b0010000, 2'd3, 2'd0, 2'd0, 3'd0, 3'd0, 3'd2, 3'd0};
            controlPkg::Slt:            w = {7'b0010000, 2'd3, 2'd1, 2'd0, 3'd0, 3'd7, 3'd4, 3'd0};
            controlPkg::Break:          w = {7'b1000000, 2'd0, 2'd0, 2'd0, 3'd1, 3'd2, 3'd0, 3'd0};
            controlPkg::Addi:           w = {7'b0000010, 2'd0, 2'd1, 2'd0, 3'd3, 3'd1, 3'd0, 3'd0};
            controlPkg::ImmEnd:         w = {7'b0010000, 2'd0, 2'd0, 2'd0, 3'd0, 3'd0, 3'd0, 3'd0};
            default:                    w = '0;
        endcase
        return w;
    endfunction

    // Expected state sequence of one instruction, from Fetch through Delay
    task automatic buildRoute(input controlPkg::instrKind k);
        route = '{controlPkg::Fetch, controlPkg::PcWait, controlPkg::IrLoad, controlPkg::Decode,
                  controlPkg::DecodeWait};
        case (k)
            controlPkg::KAdd:   route.push_back(controlPkg::AluAdd);
            controlPkg::KSub:   route.push_back(controlPkg::AluSub);
            controlPkg::KAnd:   route.push_back(controlPkg::AluAnd);
            controlPkg::KSll:   route.push_back(controlPkg::ShiftLoadShamt);
            controlPkg::KSrl:   route.push_back(controlPkg::ShiftLoadShamt);
            controlPkg::KSra:   route.push_back(controlPkg::ShiftLoadShamt);
            controlPkg::KSllv:  route.push_back(controlPkg::ShiftLoadRt);
            controlPkg::KSrav:  route.push_back(controlPkg::ShiftLoadRt);
            controlPkg::KSlt:   route.push_back(controlPkg::Slt);
            controlPkg::KBreak: route.push_back(controlPkg::Break);
            controlPkg::KAddi:  route.push_back(controlPkg::Addi);
            default:            ;
        endcase
        case (k)
            controlPkg::KAdd,
            controlPkg::KSub,
            controlPkg::KAnd:   route.push_back(controlPkg::AluEnd);
            controlPkg::KSll:   route.push_back(controlPkg::ShiftSll);
            controlPkg::KSrl:   route.push_back(controlPkg::ShiftSrl);
            controlPkg::KSra:   route.push_back(controlPkg::ShiftSra);
            controlPkg::KSllv:  route.push_back(controlPkg::ShiftSllv);
            controlPkg::KSrav:  route.push_back(controlPkg::ShiftSrav);
            controlPkg::KAddi:  route.push_back(controlPkg::ImmEnd);
            default:            ;
        endcase
        if (k inside {controlPkg::KSll, controlPkg::KSrl, controlPkg::KSra,
                      controlPkg::KSllv, controlPkg::KSrav}) begin
            route.push_back(controlPkg::ShiftWait);
            route.push_back(controlPkg::ShiftEnd);
        end
        route.push_back(controlPkg::Delay);
    endtask

    // Eleven kept encodings and one slot for an unknown encoding, equally likely
    task automatic pickInstr(output logic [`OPCODE_W-1:0] op, output logic [`FUNCT_W-1:0] fn,
                             output controlPkg::instrKind k);
        logic [3:0] pick;
        pick = 4'($unsigned($random(seed)) % 12);
        fn = 6'($random(seed));
        if (pick < 4'd10) begin
            op = `OP_RTYPE;
            fn = FUNCTS[pick];
            k = KINDS[pick];
        end else if (pick == 4'd10) begin
            op = `OP_ADDI;
            k = controlPkg::KAddi;
        end else begin
            op = `OP_RTYPE;
            // Either an R-format funct the decoder lacks or an opcode it lacks
            if ($random(seed) & 1) begin
                while (fn inside {`FN_ADD, `FN_SUB, `FN_AND, `FN_SLL, `FN_SRL, `FN_SRA,
                                  `FN_SLLV, `FN_SRAV, `FN_SLT, `FN_BREAK}) begin
                    fn = 6'($random(seed));
                end
            end else begin
                while (op == `OP_RTYPE || op == `OP_ADDI) begin
                    op = 6'($random(seed));
                end
            end
            k = controlPkg::KUnknown;
        end
    endtask

    task automatic checkEqual(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "Control word mismatch in %s", name);
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            $display("Run never finished within %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        logic [`OPCODE_W-1:0]  op;
        logic [`FUNCT_W-1:0]   fn;
        controlPkg::instrKind  kind;
        controlPkg::ctrlState  st;
        opcode = '0;
        funct = '0;
        seed = 32'h31a7;
        @(negedge reset);
        checkEqual("after reset", 32'd0, {7'd0, dutWord});
        for (int n = 0; n < NUM_INSTR; n++) begin
            pickInstr(op, fn, kind);
            opcode = op;
            funct = fn;
            buildRoute(kind);
            // Each word shows up one cycle after its state
            foreach (route[j]) begin
                @(negedge clk);
                st = route[j];
                checkEqual($sformatf("instr %0d %s in %s", n, kind.name(), st.name()),
                           {7'd0, wordOf(st)}, {7'd0, dutWord});
            end
        end
        $display("All checks passed");
        $finish;
    end

endmodule

//--- multicycleControl.f
+incdir+logic
logic/controlPkg.sv
logic/ctrlBus.sv
logic/instrDecoder.sv
logic/controlSequencer.sv
logic/controlEncoder.sv
logic/multicycleControl.sv
tb/clockGen.sv
tb/multicycleControlTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module multicycleControlTb \
    -f multicycleControl.f -Mdir obj_dir -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi
exit 0
